//--- source/rv_pkg.sv
//////////////////////////////
// RV32I shared definitions
//////////////////////////////

package rv_pkg;

	localparam int XLEN      = 32;
	localparam int CNT_WIDTH = 64; // Cycle and instret width

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [3:0]      strb_t; // One bit per byte lane

	// Major opcodes of the base integer set
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		UNIT_ALU,
		UNIT_LUI,
		UNIT_AUIPC,
		UNIT_LINK,   // JAL and JALR
		UNIT_LOAD,
		UNIT_STORE,
		UNIT_BRANCH,
		UNIT_CSR
	} unit_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_t;

	typedef enum logic [1:0] {
		CSR_SEL_CYCLE, CSR_SEL_CYCLEH, CSR_SEL_INSTRET, CSR_SEL_INSTRETH
	} csr_sel_t;

	// funct3 codes
	localparam logic [2:0] F3_BEQ  = 3'b000, F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100, F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110, F3_BGEU = 3'b111;
	localparam logic [2:0] F3_LB   = 3'b000, F3_LH   = 3'b001, F3_LW = 3'b010;
	localparam logic [2:0] F3_LBU  = 3'b100, F3_LHU  = 3'b101;
	localparam logic [2:0] F3_SB   = 3'b000, F3_SH   = 3'b001, F3_SW = 3'b010;
	localparam logic [2:0] F3_ADD_SUB = 3'b000, F3_SLL = 3'b001, F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011, F3_XOR = 3'b100, F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110, F3_AND = 3'b111;
	localparam logic [2:0] F3_CSRRS   = 3'b010; // Counter reads use csrrs rd, csr, x0

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

	// Readable counter CSR numbers
	localparam logic [11:0] CSR_CYCLE    = 12'hC00;
	localparam logic [11:0] CSR_INSTRET  = 12'hC02;
	localparam logic [11:0] CSR_CYCLEH   = 12'hC80;
	localparam logic [11:0] CSR_INSTRETH = 12'hC82;

endpackage

//--- source/rv_decode_if.sv
//////////////////////////////
// Decode to execute bundle
//////////////////////////////

`timescale 1ns/10ps

interface rv_decode_if import rv_pkg::*; ();

	unit_t    unit;    // Result source
	alu_op_t  alu_op;
	logic [2:0] funct3; // Branch condition or access width
	word_t    imm;
	logic     use_imm; // ALU operand b is imm, for link a register-relative target
	csr_sel_t csr_sel;

	modport decoder (
		output unit,
		output alu_op,
		output funct3,
		output imm,
		output use_imm,
		output csr_sel
	);

	modport exec (
		input unit,
		input alu_op,
		input funct3,
		input imm,
		input use_imm,
		input csr_sel
	);

endinterface

//--- source/rv_insn_decode.sv
//////////////////////////////
// RV32I instruction decoder
//////////////////////////////

`timescale 1ns/10ps

module rv_insn_decode import rv_pkg::*; (
	input  word_t         insn,
	input  logic          insn_valid,
	rv_decode_if.decoder  dec,
	output reg_addr_t     rs1_addr,
	output reg_addr_t     rs2_addr,
	output reg_addr_t     rd_addr,
	output logic          rd_en,
	output logic          illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	word_t      imm_u;
	logic       is_imm;
	logic       use_rs1;
	logic       use_rs2;
	logic       use_rd;
	logic       legal;

	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};

	assign is_imm = (opcode == OPC_OP_IMM);

	always_comb begin
		dec.unit    = UNIT_ALU;
		dec.alu_op  = ALU_ADD;
		dec.funct3  = funct3;
		dec.imm     = imm_i;
		dec.use_imm = 1'b0;
		dec.csr_sel = CSR_SEL_CYCLE;
		use_rs1     = 1'b0;
		use_rs2     = 1'b0;
		use_rd      = 1'b0;
		legal       = 1'b0;

		case (opcode)
			OPC_LUI: begin
				dec.unit = UNIT_LUI;
				dec.imm  = imm_u;
				use_rd   = 1'b1;
				legal    = 1'b1;
			end
			OPC_AUIPC: begin
				dec.unit = UNIT_AUIPC;
				dec.imm  = imm_u;
				use_rd   = 1'b1;
				legal    = 1'b1;
			end
			OPC_JAL: begin
				dec.unit = UNIT_LINK; // pc-relative target
				dec.imm  = imm_j;
				use_rd   = 1'b1;
				legal    = 1'b1;
			end
			OPC_JALR: begin
				dec.unit    = UNIT_LINK;
				dec.use_imm = 1'b1; // Target from rs1
				use_rs1     = 1'b1;
				use_rd      = 1'b1;
				legal       = (funct3 == 3'b000);
			end
			OPC_BRANCH: begin
				dec.unit = UNIT_BRANCH;
				dec.imm  = imm_b;
				use_rs1  = 1'b1;
				use_rs2  = 1'b1;
				legal    = (funct3 != 3'b010) && (funct3 != 3'b011);
			end
			OPC_LOAD: begin
				dec.unit = UNIT_LOAD;
				use_rs1  = 1'b1;
				use_rd   = 1'b1;
				legal    = (funct3 == F3_LB) || (funct3 == F3_LH) || (funct3 == F3_LW) ||
					(funct3 == F3_LBU) || (funct3 == F3_LHU);
			end
			OPC_STORE: begin
				dec.unit = UNIT_STORE;
				dec.imm  = imm_s;
				use_rs1  = 1'b1;
				use_rs2  = 1'b1;
				legal    = (funct3 == F3_SB) || (funct3 == F3_SH) || (funct3 == F3_SW);
			end
			OPC_OP, OPC_OP_IMM: begin
				dec.use_imm = is_imm;
				use_rs1     = 1'b1;
				use_rs2     = !is_imm;
				use_rd      = 1'b1;
				case (funct3)
					F3_ADD_SUB: begin
						if (is_imm || funct7 == F7_BASE) begin
							legal = 1'b1;
						end else if (funct7 == F7_ALT) begin
							dec.alu_op = ALU_SUB;
							legal      = 1'b1;
						end
					end
					F3_SLL: begin
						dec.alu_op = ALU_SLL;
						legal      = (funct7 == F7_BASE); // Shamt bit 5 is reserved
					end
					F3_SRL_SRA: begin
						dec.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
						legal      = (funct7 == F7_BASE) || (funct7 == F7_ALT);
					end
					F3_SLT:  dec.alu_op = ALU_SLT;
					F3_SLTU: dec.alu_op = ALU_SLTU;
					F3_XOR:  dec.alu_op = ALU_XOR;
					F3_OR:   dec.alu_op = ALU_OR;
					default: dec.alu_op = ALU_AND;
				endcase
				if (funct3 != F3_ADD_SUB && funct3 != F3_SLL && funct3 != F3_SRL_SRA) begin
					legal = is_imm || (funct7 == F7_BASE);
				end
			end
			OPC_SYSTEM: begin
				dec.unit = UNIT_CSR;
				use_rd   = 1'b1;
				if (insn[19:15] == 5'd0 && funct3 == F3_CSRRS) begin
					legal = 1'b1;
					case (insn[31:20])
						CSR_CYCLE:    dec.csr_sel = CSR_SEL_CYCLE;
						CSR_CYCLEH:   dec.csr_sel = CSR_SEL_CYCLEH;
						CSR_INSTRET:  dec.csr_sel = CSR_SEL_INSTRET;
						CSR_INSTRETH: dec.csr_sel = CSR_SEL_INSTRETH;
						default:      legal = 1'b0; // time and the rest trap
					endcase
				end
			end
			default: legal = 1'b0;
		endcase

		if (!legal) begin
			dec.unit = UNIT_ALU; // No memory request for bad encodings
		end
	end

	assign rs1_addr = use_rs1 ? insn[19:15] : '0;
	assign rs2_addr = use_rs2 ? insn[24:20] : '0;
	assign rd_addr  = use_rd ? insn[11:7] : '0;
	assign rd_en    = use_rd && legal;
	assign illegal  = insn_valid && !legal;

endmodule

//--- source/rv_exec_unit.sv
//////////////////////////////
// RV32I execution unit
//////////////////////////////

`timescale 1ns/10ps

module rv_exec_unit import rv_pkg::*; (
	rv_decode_if.exec dec,
	input  word_t     pc,
	input  word_t     rs1_data,
	input  word_t     rs2_data,
	input  word_t     csr_data,
	input  word_t     mem_rdata,
	input  logic      insn_valid,
	output word_t     rd_wdata,
	output word_t     next_pc,
	output logic      misaligned,
	output logic      mem_valid,
	output word_t     mem_addr,
	output word_t     mem_wdata,
	output strb_t     mem_wstrb,
	output strb_t     mem_rmask
);

	word_t op_b;
	word_t alu_result;
	word_t pc_plus4;
	word_t pc_rel;
	word_t eff_addr;
	word_t jump_target;
	word_t load_data;
	logic  cmp_eq;
	logic  cmp_lt;
	logic  cmp_ltu;
	logic  br_taken;
	strb_t size_mask;

	assign op_b     = dec.use_imm ? dec.imm : rs2_data;
	assign pc_plus4 = pc + 32'd4;
	assign pc_rel   = pc + dec.imm;      // AUIPC, JAL and branch target
	assign eff_addr = rs1_data + dec.imm; // Load/store address and JALR sum

	assign jump_target = dec.use_imm ? {eff_addr[XLEN-1:1], 1'b0} : pc_rel;

	assign cmp_eq  = (rs1_data == op_b);
	assign cmp_lt  = ($signed(rs1_data) < $signed(op_b));
	assign cmp_ltu = (rs1_data < op_b);

	always_comb begin
		case (dec.alu_op)
			ALU_SUB:  alu_result = rs1_data - op_b;
			ALU_SLL:  alu_result = rs1_data << op_b[4:0];
			ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, cmp_lt};
			ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, cmp_ltu};
			ALU_XOR:  alu_result = rs1_data ^ op_b;
			ALU_SRL:  alu_result = rs1_data >> op_b[4:0];
			ALU_SRA:  alu_result = $signed(rs1_data) >>> op_b[4:0];
			ALU_OR:   alu_result = rs1_data | op_b;
			ALU_AND:  alu_result = rs1_data & op_b;
			default:  alu_result = rs1_data + op_b;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			F3_BEQ:  br_taken = cmp_eq;
			F3_BNE:  br_taken = !cmp_eq;
			F3_BLT:  br_taken = cmp_lt;
			F3_BGE:  br_taken = !cmp_lt;
			F3_BLTU: br_taken = cmp_ltu;
			F3_BGEU: br_taken = !cmp_ltu;
			default: br_taken = 1'b0;
		endcase
	end

	// Low lanes only, address bits ignored
	always_comb begin
		case (dec.funct3)
			F3_LB:   load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			F3_LH:   load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			F3_LBU:  load_data = {24'b0, mem_rdata[7:0]};
			F3_LHU:  load_data = {16'b0, mem_rdata[15:0]};
			default: load_data = mem_rdata;
		endcase
		case (dec.funct3[1:0])
			2'b00:   size_mask = 4'b0001;
			2'b01:   size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	always_comb begin
		rd_wdata  = alu_result;
		next_pc   = pc_plus4;
		mem_valid = 1'b0;
		mem_addr  = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		mem_rmask = '0;
		case (dec.unit)
			UNIT_LUI:   rd_wdata = dec.imm;
			UNIT_AUIPC: rd_wdata = pc_rel;
			UNIT_LINK: begin
				rd_wdata = pc_plus4;
				next_pc  = jump_target;
			end
			UNIT_LOAD: begin
				mem_valid = insn_valid;
				mem_addr  = eff_addr;
				mem_rmask = size_mask;
				rd_wdata  = load_data;
			end
			UNIT_STORE: begin
				mem_valid = insn_valid;
				mem_addr  = eff_addr;
				mem_wdata = rs2_data;
				mem_wstrb = size_mask;
			end
			UNIT_BRANCH: begin
				if (br_taken) begin
					next_pc = pc_rel;
				end
			end
			UNIT_CSR:   rd_wdata = csr_data;
			default:    rd_wdata = alu_result;
		endcase
	end

	assign misaligned = insn_valid && (next_pc[1:0] != 2'b00) &&
		(dec.unit == UNIT_LINK || dec.unit == UNIT_BRANCH);

endmodule

//--- source/rv_regfile.sv
//////////////////////////////
// Integer register file
//////////////////////////////

`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
	input  logic      clk,
	input  reg_addr_t rs1_addr,
	input  reg_addr_t rs2_addr,
	input  reg_addr_t rd_addr,
	input  logic      we,
	input  word_t     rd_wdata,
	output word_t     rs1_data,
	output word_t     rs2_data
);

	word_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (we && rd_addr != 5'd0) begin
			regs[rd_addr] <= rd_wdata;
		end
	end

	// Asynchronous read ports
	always_comb begin
		rs1_data = '0;
		rs2_data = '0;
		if (rs1_addr != 5'd0) begin
			rs1_data = regs[rs1_addr];
		end
		if (rs2_addr != 5'd0) begin
			rs2_data = regs[rs2_addr];
		end
	end

endmodule

//--- source/rv_counters.sv
//////////////////////////////
// Cycle and instret counters
//////////////////////////////

`timescale 1ns/10ps

module rv_counters import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     retire,
	input  csr_sel_t csr_sel,
	output word_t    csr_data
);

	logic [CNT_WIDTH-1:0] cycle_cnt;
	logic [CNT_WIDTH-1:0] instret_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cycle_cnt   <= '0;
			instret_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1; // Every edge out of reset
			if (retire) begin
				instret_cnt <= instret_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		case (csr_sel)
			CSR_SEL_CYCLEH:   csr_data = cycle_cnt[CNT_WIDTH-1:XLEN];
			CSR_SEL_INSTRET:  csr_data = instret_cnt[XLEN-1:0];
			CSR_SEL_INSTRETH: csr_data = instret_cnt[CNT_WIDTH-1:XLEN];
			default:          csr_data = cycle_cnt[XLEN-1:0];
		endcase
	end

endmodule

//--- source/rv_core_top.sv
//////////////////////////////
// RV32I single-cycle core
//////////////////////////////

`timescale 1ns/10ps

module rv_core_top import rv_pkg::*; #(
	parameter word_t RESET_ADDR = '0
) (
	input  logic  clk,
	input  logic  rst_n,
	input  word_t insn,
	input  logic  insn_valid,
	output word_t insn_addr,
	output logic  insn_complete,
	output logic  trap,
	output logic  mem_valid,
	input  logic  mem_ready,
	output word_t mem_addr,
	output word_t mem_wdata,
	output strb_t mem_wstrb,
	output strb_t mem_rmask,
	input  word_t mem_rdata
);

	word_t     pc;
	word_t     next_pc;
	word_t     rs1_data;
	word_t     rs2_data;
	word_t     rd_wdata;
	word_t     csr_data;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	reg_addr_t rd_addr;
	logic      rd_en;
	logic      illegal;
	logic      misaligned;

	rv_decode_if dec_if ();

	assign insn_addr     = pc;
	assign trap          = illegal || misaligned; // Both already qualified by insn_valid
	assign insn_complete = insn_valid && !trap && (!mem_valid || mem_ready);

	// pc holds on trap and memory stall
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_ADDR;
		end else if (insn_complete) begin
			pc <= next_pc;
		end
	end

	rv_insn_decode u_decode (
		.insn       (insn),
		.insn_valid (insn_valid),
		.dec        (dec_if.decoder),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.rd_addr    (rd_addr),
		.rd_en      (rd_en),
		.illegal    (illegal)
	);

	rv_exec_unit u_exec (
		.dec        (dec_if.exec),
		.pc         (pc),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.csr_data   (csr_data),
		.mem_rdata  (mem_rdata),
		.insn_valid (insn_valid),
		.rd_wdata   (rd_wdata),
		.next_pc    (next_pc),
		.misaligned (misaligned),
		.mem_valid  (mem_valid),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_wstrb  (mem_wstrb),
		.mem_rmask  (mem_rmask)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rd_addr  (rd_addr),
		.we       (insn_complete && rd_en), // Write back on retire
		.rd_wdata (rd_wdata),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	rv_counters u_counters (
		.clk      (clk),
		.rst_n    (rst_n),
		.retire   (insn_complete),
		.csr_sel  (dec_if.csr_sel),
		.csr_data (csr_data)
	);

endmodule

//--- testbench/tb_rv_core.sv
//////////////////////////////
// RV32I core testbench
//////////////////////////////

`timescale 1ns/10ps

module tb_rv_core import rv_pkg::*; ();

	localparam int CLK_PERIOD     = 20;
	localparam int TEST_INSNS     = 150; // Instructions issued over all tests, rounded up
	localparam int TEST_CYCLES    = TEST_INSNS * 2 + 60; // Two cycles each plus stalls and traps
	localparam int WATCHDOG_NS    = TEST_CYCLES * 2 * CLK_PERIOD;
	localparam int COMPLETE_LIMIT = 16;

	logic  clk = 1'b0;
	logic  rst_n;
	word_t insn;
	logic  insn_valid;
	word_t insn_addr;
	logic  insn_complete;
	logic  trap;
	logic  mem_valid;
	logic  mem_ready;
	word_t mem_addr;
	word_t mem_wdata;
	strb_t mem_wstrb;
	strb_t mem_rmask;
	word_t mem_rdata;

	word_t xreg [0:31];          // Register model
	word_t pc_model = 32'h100;
	word_t rng_state = 32'he299;
	int    retired = 0;          // Completions since reset
	int    edge_cnt = 0;         // Rising edges since reset release

	rv_core_top #(.RESET_ADDR(32'h100)) dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.insn          (insn),
		.insn_valid    (insn_valid),
		.insn_addr     (insn_addr),
		.insn_complete (insn_complete),
		.trap          (trap),
		.mem_valid     (mem_valid),
		.mem_ready     (mem_ready),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_wstrb     (mem_wstrb),
		.mem_rmask     (mem_rmask),
		.mem_rdata     (mem_rdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		if (rst_n) begin
			edge_cnt <= edge_cnt + 1;
		end
	end

	function automatic word_t next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic word_t sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	// Instruction encoders
	function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t enc_b(input word_t off, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic word_t enc_j(input word_t off, input reg_addr_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	// Branch condition from the ISA definition
	function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic fail_run();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic set_reg(input reg_addr_t rd, input word_t value);
		if (rd != 5'd0) begin
			xreg[rd] = value;
		end
	endtask

	task automatic present_insn(input word_t i, input string name);
		@(posedge clk);
		insn       <= i;
		insn_valid <= 1'b1;
		@(negedge clk);
		check_eq({name, " pc"}, pc_model, insn_addr);
	endtask

	// Waits for completion, retires on the next edge and checks the new pc
	task automatic finish_insn(input word_t exp_next, input string name);
		int n;
		n = 0;
		check_eq({name, " trap"}, 32'd0, trap);
		while (insn_complete !== 1'b1) begin
			if (n == COMPLETE_LIMIT) begin
				$display("Error: %s did not complete within %0d cycles", name, n);
				fail_run();
			end
			@(negedge clk);
			n++;
		end
		@(posedge clk);
		insn_valid <= 1'b0;
		mem_ready  <= 1'b1;
		retired++;
		pc_model = exp_next;
		@(negedge clk);
		check_eq({name, " next pc"}, pc_model, insn_addr);
	endtask

	task automatic step(input word_t i, input string name);
		present_insn(i, name);
		finish_insn(pc_model + 32'd4, name);
	endtask

	// Register contents seen through a SW to address 4*r
	task automatic check_reg(input reg_addr_t r, input string name);
		present_insn(enc_s({5'd0, r, 2'b00}, r, 5'd0, 3'b010), name);
		check_eq({name, " store valid"}, 32'd1, mem_valid);
		check_eq({name, " store addr"}, {25'd0, r, 2'b00}, mem_addr);
		check_eq({name, " store strb"}, 32'hF, mem_wstrb);
		check_eq({name, " value"}, xreg[r], mem_wdata);
		finish_insn(pc_model + 32'd4, name);
	endtask

	task automatic load_const(input reg_addr_t rd, input word_t value);
		word_t upper;
		upper = (value + 32'h800) >> 12;
		step({upper[19:0], rd, OPC_LUI}, "lui");
		set_reg(rd, {upper[19:0], 12'b0});
		step(enc_i(value[11:0], rd, 3'b000, rd, OPC_OP_IMM), "addi");
		set_reg(rd, value);
	endtask

	task automatic op_reg(input logic [6:0] f7, input logic [2:0] f3, input reg_addr_t rd,
		input reg_addr_t rs1, input reg_addr_t rs2, input word_t exp, input string name);
		step(enc_r(f7, rs2, rs1, f3, rd), name);
		set_reg(rd, exp);
		check_reg(rd, name);
	endtask

	task automatic op_imm(input logic [11:0] imm, input logic [2:0] f3, input reg_addr_t rd,
		input reg_addr_t rs1, input word_t exp, input string name);
		step(enc_i(imm, rs1, f3, rd, OPC_OP_IMM), name);
		set_reg(rd, exp);
		check_reg(rd, name);
	endtask

	task automatic check_request(input word_t exp_addr, input strb_t exp_rmask,
		input strb_t exp_wstrb, input string name);
		check_eq({name, " mem_valid"}, 32'd1, mem_valid);
		check_eq({name, " pc held"}, pc_model, insn_addr);
		check_eq({name, " mem_addr"}, exp_addr, mem_addr);
		check_eq({name, " mem_rmask"}, exp_rmask, mem_rmask);
		check_eq({name, " mem_wstrb"}, exp_wstrb, mem_wstrb);
	endtask

	// Load or store held off by mem_ready for a number of cycles
	task automatic mem_insn(input word_t i, input int stall, input word_t rdata,
		input word_t exp_addr, input strb_t exp_rmask, input strb_t exp_wstrb,
		input word_t exp_wdata, input string name);
		@(posedge clk);
		insn       <= i;
		insn_valid <= 1'b1;
		mem_ready  <= 1'b0;
		mem_rdata  <= rdata;
		repeat (stall) begin
			@(negedge clk);
			check_request(exp_addr, exp_rmask, exp_wstrb, name);
			check_eq({name, " complete while stalled"}, 32'd0, insn_complete);
			@(posedge clk);
		end
		mem_ready <= 1'b1;
		@(negedge clk);
		check_request(exp_addr, exp_rmask, exp_wstrb, name);
		if (exp_wstrb != 4'b0000) begin
			check_eq({name, " mem_wdata"}, exp_wdata, mem_wdata);
		end
		finish_insn(pc_model + 32'd4, name);
	endtask

	task automatic load_case(input logic [2:0] f3, input int stall, input word_t rdata,
		input strb_t rmask, input word_t exp, input string name);
		mem_insn(enc_i(12'h010, 5'd12, f3, 5'd11, OPC_LOAD), stall, rdata,
			xreg[12] + 32'h10, rmask, 4'b0000, 32'd0, name);
		set_reg(5'd11, exp);
		check_reg(5'd11, name);
	endtask

	task automatic branch_case(input logic [2:0] f3, input reg_addr_t rs1, input reg_addr_t rs2,
		input word_t off);
		word_t target;
		target = branch_taken(f3, xreg[rs1], xreg[rs2]) ? pc_model + off : pc_model + 32'd4;
		present_insn(enc_b(off, rs2, rs1, f3), $sformatf("branch f3=%0d", f3));
		finish_insn(target, $sformatf("branch f3=%0d", f3));
	endtask

	task automatic read_counter(input logic [11:0] csr, input reg_addr_t rd, input string name);
		word_t exp;
		present_insn(enc_i(csr, 5'd0, 3'b010, rd, OPC_SYSTEM), name);
		case (csr)
			12'hC00: exp = edge_cnt;
			12'hC02: exp = retired;
			default: exp = 32'd0; // High halves stay zero in a short run
		endcase
		finish_insn(pc_model + 32'd4, name);
		set_reg(rd, exp);
		check_reg(rd, name);
	endtask

	// Presents a bad instruction for two cycles, then withdraws it
	task automatic trap_insn(input word_t i, input string name);
		present_insn(i, name);
		check_eq({name, " trap"}, 32'd1, trap);
		check_eq({name, " complete"}, 32'd0, insn_complete);
		@(posedge clk);
		@(negedge clk);
		check_eq({name, " pc held"}, pc_model, insn_addr);
		check_eq({name, " trap held"}, 32'd1, trap);
		@(posedge clk);
		insn_valid <= 1'b0;
		@(negedge clk);
		check_eq({name, " pc after"}, pc_model, insn_addr);
		check_eq({name, " trap cleared"}, 32'd0, trap);
	endtask

	task automatic test_reset();
		@(negedge clk);
		check_eq("reset pc", 32'h100, insn_addr);
		check_eq("reset mem_valid", 32'd0, mem_valid);
		check_eq("reset trap", 32'd0, trap);
		check_eq("reset complete", 32'd0, insn_complete);
	endtask

	task automatic test_alu();
		logic [11:0] imm;
		word_t       rnd;
		word_t       exp;
		load_const(5'd1, next_rand());
		load_const(5'd2, next_rand());
		load_const(5'd3, next_rand());
		load_const(5'd4, 32'h8000_0010);
		op_reg(7'h00, 3'b000, 5'd5, 5'd1, 5'd2, xreg[1] + xreg[2], "add");
		op_reg(7'h20, 3'b000, 5'd5, 5'd1, 5'd2, xreg[1] - xreg[2], "sub");
		op_reg(7'h00, 3'b001, 5'd5, 5'd1, 5'd3, xreg[1] << xreg[3][4:0], "sll");
		op_reg(7'h00, 3'b010, 5'd5, 5'd1, 5'd2, $signed(xreg[1]) < $signed(xreg[2]), "slt");
		op_reg(7'h00, 3'b011, 5'd5, 5'd1, 5'd2, xreg[1] < xreg[2], "sltu");
		op_reg(7'h00, 3'b100, 5'd5, 5'd1, 5'd2, xreg[1] ^ xreg[2], "xor");
		op_reg(7'h00, 3'b101, 5'd5, 5'd4, 5'd3, xreg[4] >> xreg[3][4:0], "srl");
		op_reg(7'h20, 3'b101, 5'd5, 5'd4, 5'd3, $signed(xreg[4]) >>> xreg[3][4:0], "sra");
		op_reg(7'h00, 3'b110, 5'd5, 5'd1, 5'd2, xreg[1] | xreg[2], "or");
		op_reg(7'h00, 3'b111, 5'd5, 5'd1, 5'd2, xreg[1] & xreg[2], "and");
		rnd = next_rand();
		imm = rnd[11:0];
		op_imm(imm, 3'b000, 5'd6, 5'd1, xreg[1] + sext12(imm), "addi");
		op_imm(imm, 3'b010, 5'd6, 5'd1, $signed(xreg[1]) < $signed(sext12(imm)), "slti");
		op_imm(imm, 3'b011, 5'd6, 5'd1, xreg[1] < sext12(imm), "sltiu");
		op_imm(imm, 3'b100, 5'd6, 5'd2, xreg[2] ^ sext12(imm), "xori");
		op_imm(imm, 3'b110, 5'd6, 5'd2, xreg[2] | sext12(imm), "ori");
		op_imm(imm, 3'b111, 5'd6, 5'd2, xreg[2] & sext12(imm), "andi");
		op_imm(12'h007, 3'b001, 5'd6, 5'd4, xreg[4] << 7, "slli");
		op_imm(12'h00D, 3'b101, 5'd6, 5'd4, xreg[4] >> 13, "srli");
		op_imm(12'h40D, 3'b101, 5'd6, 5'd4, $signed(xreg[4]) >>> 13, "srai");
		exp = pc_model + 32'h1234_5000;
		step({20'h12345, 5'd8, OPC_AUIPC}, "auipc");
		set_reg(5'd8, exp);
		check_reg(5'd8, "auipc");
		op_imm(12'h005, 3'b000, 5'd0, 5'd1, xreg[1] + 32'd5, "addi x0"); // x0 stays zero
		op_reg(7'h00, 3'b000, 5'd0, 5'd1, 5'd2, xreg[1] + xreg[2], "add x0");
	endtask

	task automatic test_memory();
		word_t neg;
		word_t pos;
		load_const(5'd12, 32'h0000_0800);
		load_const(5'd13, next_rand());
		neg = next_rand() | 32'h0000_8080; // Sign bits of byte and half set
		pos = next_rand() & 32'hFFFF_7F7F;
		load_case(3'b000, 3, neg, 4'b0001, {{24{neg[7]}}, neg[7:0]}, "lb");
		load_case(3'b100, 2, neg, 4'b0001, {24'd0, neg[7:0]}, "lbu");
		load_case(3'b001, 4, neg, 4'b0011, {{16{neg[15]}}, neg[15:0]}, "lh");
		load_case(3'b101, 1, neg, 4'b0011, {16'd0, neg[15:0]}, "lhu");
		load_case(3'b001, 2, pos, 4'b0011, {{16{pos[15]}}, pos[15:0]}, "lh positive");
		load_case(3'b010, 3, pos, 4'b1111, pos, "lw");
		mem_insn(enc_s(12'h004, 5'd13, 5'd12, 3'b000), 3, 32'd0, xreg[12] + 32'd4,
			4'b0000, 4'b0001, xreg[13], "sb");
		mem_insn(enc_s(12'hFFE, 5'd13, 5'd12, 3'b001), 2, 32'd0, xreg[12] - 32'd2,
			4'b0000, 4'b0011, xreg[13], "sh");
		mem_insn(enc_s(12'h020, 5'd13, 5'd12, 3'b010), 4, 32'd0, xreg[12] + 32'h20,
			4'b0000, 4'b1111, xreg[13], "sw");
	endtask

	task automatic test_control();
		logic [2:0] br_f3 [0:5];
		word_t      link;
		br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		load_const(5'd1, 32'hFFFF_FFFB); // -5, large when unsigned
		load_const(5'd2, 32'd3);
		for (int k = 0; k < 6; k++) begin
			branch_case(br_f3[k], 5'd1, 5'd2, 32'd16);
			branch_case(br_f3[k], 5'd2, 5'd1, 32'hFFFF_FFF8);
			branch_case(br_f3[k], 5'd1, 5'd1, 32'd12);
		end
		link = pc_model + 32'd4;
		present_insn(enc_j(32'd40, 5'd5), "jal");
		finish_insn(pc_model + 32'd40, "jal");
		set_reg(5'd5, link);
		check_reg(5'd5, "jal link");
		load_const(5'd6, 32'h0000_0400);
		link = pc_model + 32'd4;
		present_insn(enc_i(12'd5, 5'd6, 3'b000, 5'd7, OPC_JALR), "jalr");
		finish_insn((xreg[6] + 32'd5) & 32'hFFFF_FFFE, "jalr");
		set_reg(5'd7, link);
		check_reg(5'd7, "jalr link");
		link = pc_model + 32'd4;
		present_insn(enc_i(12'hFFC, 5'd6, 3'b000, 5'd8, OPC_JALR), "jalr back");
		finish_insn(xreg[6] - 32'd4, "jalr back");
		set_reg(5'd8, link);
		check_reg(5'd8, "jalr back link");
	endtask

	task automatic test_counters();
		read_counter(12'hC02, 5'd9, "rdinstret");
		read_counter(12'hC00, 5'd10, "rdcycle");
		read_counter(12'hC82, 5'd11, "rdinstreth");
		read_counter(12'hC80, 5'd12, "rdcycleh");
	endtask

	task automatic test_traps();
		trap_insn(32'h0000_007F, "unknown opcode");
		trap_insn(enc_r(7'h20, 5'd2, 5'd1, 3'b110, 5'd13), "or with alt funct7");
		check_reg(5'd13, "x13 after trap"); // Trapped OR left no write
		trap_insn(enc_i(12'hC01, 5'd0, 3'b010, 5'd14, OPC_SYSTEM), "rdtime");
		load_const(5'd10, 32'h0000_0200);
		trap_insn(enc_i(12'd2, 5'd10, 3'b000, 5'd15, OPC_JALR), "jalr misaligned");
		step(enc_i(12'h001, 5'd10, 3'b000, 5'd16, OPC_OP_IMM), "addi after traps");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		fail_run();
	end

	initial begin
		rst_n      = 1'b0;
		insn       = 32'd0;
		insn_valid = 1'b0;
		mem_ready  = 1'b1;
		mem_rdata  = 32'd0;
		for (int r = 0; r < 32; r++) begin
			xreg[r] = 32'd0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_alu();
		test_memory();
		test_control();
		test_counters();
		test_traps();
		@(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- filelist.f
source/rv_pkg.sv
source/rv_decode_if.sv
source/rv_insn_decode.sv
source/rv_exec_unit.sv
source/rv_regfile.sv
source/rv_counters.sv
source/rv_core_top.sv
testbench/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_decode_if.sv
  - source/rv_insn_decode.sv
  - source/rv_exec_unit.sv
  - source/rv_regfile.sv
  - source/rv_counters.sv
  - source/rv_core_top.sv
  - target: test
    files:
      - testbench/tb_rv_core.sv
